//--- list.f
+incdir+dv
src/net_pkg.sv
src/second_tick.sv
src/link_sequencer.sv
src/tx_arbiter.sv
src/net_control.sv
dv/tb_net_control.sv

//--- run.sh
#!/bin/sh
# build and run the control core testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert -f list.f --top-module tb_net_control -o tb_net_control
./obj_dir/tb_net_control > sim.log 2>&1
cat sim.log
if grep -q "Errors found" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation passed"

//--- dv/tb_ref.svh
/*
  Testbench helpers for the control core.
  Reference model for address, renewal time and grant,
  compare tasks per result type, stimulus and wait tasks.
*/

// ----------------------------------------
// reference model
// ----------------------------------------
function automatic net_pkg::ip_addr_t expected_ip(
    input net_pkg::ip_addr_t static_addr, input logic answered,
    input net_pkg::ip_addr_t offered, input net_pkg::mac_addr_t mac);
  if (static_addr != 32'h0 && static_addr != 32'hffff_ffff) return static_addr;
  if (answered) return offered;
  return {8'd169, 8'd254, mac[15:0]};  // link-local from the mac tail
endfunction

function automatic int expected_renew_secs(input net_pkg::lease_t secs);
  if (secs == 32'h0) return 43200;  // no lease given, 12 h
  return int'(secs >> 1);           // half the lease
endfunction

function automatic net_pkg::tx_protocol_t expected_grant(input logic arp, input logic icmp,
                                                        input logic dhcp, input logic udp);
  if (arp) return net_pkg::PT_ARP;
  if (icmp) return net_pkg::PT_ICMP;
  if (dhcp) return net_pkg::PT_DHCP;
  if (udp) return net_pkg::PT_UDP;
  return net_pkg::PT_ARP;  // nothing asked, not used
endfunction

// ----------------------------------------
// compare tasks
// ----------------------------------------
task automatic check_ip(input string what, input net_pkg::ip_addr_t exp,
                        input net_pkg::ip_addr_t act);
  if (act !== exp) begin
    $display("ERROR %s: %s expected %h actual %h", test_name, what, exp, act);
    errors++;
  end
endtask

task automatic check_protocol(input string what, input net_pkg::tx_protocol_t exp,
                              input net_pkg::tx_protocol_t act);
  if (act !== exp) begin
    $display("ERROR %s: %s expected %s actual %s", test_name, what, exp.name(), act.name());
    errors++;
  end
endtask

task automatic check_bit(input string what, input logic exp, input logic act);
  if (act !== exp) begin
    $display("ERROR %s: %s expected %b actual %b", test_name, what, exp, act);
    errors++;
  end
endtask

// exact when lo == hi
task automatic check_count(input string what, input int lo, input int hi, input int act);
  if (act < lo || act > hi) begin
    $display("ERROR %s: %s expected %0d..%0d actual %0d", test_name, what, lo, hi, act);
    errors++;
  end
endtask

// ----------------------------------------
// stimulus, all on the falling edge
// ----------------------------------------
task automatic apply_reset();
  @(negedge tx_clock);
  rst_n = 1'b0;
  repeat (2) @(negedge tx_clock);  // two cycles low
  rst_n = 1'b1;
endtask

task automatic pulse_success(input net_pkg::ip_addr_t addr, input net_pkg::lease_t secs);
  ip_accept    = addr;  // valid with the pulse
  lease        = secs;
  dhcp_success = 1'b1;
  @(negedge tx_clock);
  dhcp_success = 1'b0;
endtask

task automatic wait_for(input int which, input int max_cycles, input string what,
                        output int at_cycle);
  int   n;
  logic hit;
  n        = 0;
  hit      = 1'b0;
  at_cycle = -1;
  while (!hit && n < max_cycles) begin
    @(negedge tx_clock);
    n++;
    case (which)
      W_FIXEDIP: hit = !network_state_fixedip;
      W_DHCP:    hit = !network_state_dhcp;
      default:   hit = dhcp_tx_start;
    endcase
  end
  if (hit) begin
    at_cycle = cycles;
    @(negedge tx_clock);  // address checker compares on the edge of the fall
  end else begin
    $display("%s: %s did not happen within %0d cycles", test_name, what, max_cycles);
    errors++;
  end
endtask

task automatic start_test(input string name);
  test_name   = name;
  test_errors = errors;
endtask

task automatic finish_test();
  tests_run++;
  if (errors != test_errors) begin
    tests_failed++;
  end
  $display("test %s: %s, %0d mismatches", test_name,
           (errors == test_errors) ? "pass" : "FAIL", errors - test_errors);
endtask

//--- dv/tb_net_control.sv
/*
  Testbench top for the ethernet control core.
  Clock, reset, watchdog, address checker and the tests for
  static, dhcp, fallback, renewal, link loss and arbitration.
*/
module tb_net_control;

  localparam int TPS = 8;  // cycles per simulated second
  localparam int GAP = 5;  // retransmit pause
  // test budgets in seconds: static, dhcp, fallback, renewal, link loss, arbitration
  localparam int TEST_SECONDS = 3 + 4 + 20 + 330 + 4 + 16;
  localparam int RESET_CYCLES = 5 * 2;
  localparam int CYCLE_LIMIT  = 2 * TEST_SECONDS * TPS + RESET_CYCLES;
  localparam int W_FIXEDIP = 0;  // wait_for selectors
  localparam int W_DHCP    = 1;
  localparam int W_START   = 2;

  // dut inputs, all start at known values
  logic                  tx_clock = 1'b0;
  logic                  rst_n = 1'b0;
  net_pkg::link_speed_t  link_speed = 2'b00;
  logic                  link_duplex = 1'b0;
  net_pkg::ip_addr_t     static_ip = '0;
  net_pkg::mac_addr_t    local_mac = '0;
  logic                  dhcp_success = 1'b0;
  net_pkg::ip_addr_t     ip_accept = '0;
  net_pkg::lease_t       lease = '0;
  logic                  arp_tx_request = 1'b0;
  logic                  icmp_tx_request = 1'b0;
  logic                  dhcp_tx_request = 1'b0;
  logic                  udp_tx_request = 1'b0;
  logic                  tx_active = 1'b0;
  // dut outputs
  net_pkg::ip_addr_t     local_ip;
  logic                  network_state_dhcp;
  logic                  network_state_fixedip;
  logic                  speed_1gb;
  logic                  dhcp_tx_start;
  logic                  dhcp_rx_enable;
  net_pkg::dhcp_secs_t   dhcp_seconds;
  net_pkg::tx_protocol_t tx_protocol;
  logic                  arp_tx_enable, icmp_tx_enable, dhcp_tx_enable, udp_tx_enable;
  logic [3:0]            enables;  // {arp, icmp, dhcp, udp}

  int                cycles = 0;
  int                errors = 0;
  int                test_errors = 0;
  int                tests_run = 0;
  int                tests_failed = 0;
  int                start_count = 0;  // dhcp_tx_start pulses since reset
  string             test_name = "";
  net_pkg::ip_addr_t exp_ip = '0;      // address expected when one becomes ready
  logic              fixed_q = 1'b1;
  logic              dhcp_q = 1'b1;

`include "tb_ref.svh"

  assign enables = {arp_tx_enable, icmp_tx_enable, dhcp_tx_enable, udp_tx_enable};

  net_control #(
    .ticks_per_second(TPS),
    .retry_gap_cycles(GAP)
  ) i_dut (.*);

  always #5 tx_clock = ~tx_clock;

  initial begin : watchdog
    while (cycles < CYCLE_LIMIT) begin
      @(posedge tx_clock);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Errors found");
    $finish;
  end

  // ----------------------------------------
  // address checker and pulse counter
  // ----------------------------------------
  always @(negedge tx_clock) begin
    if (!rst_n) begin
      start_count = 0;
    end else begin
      if (dhcp_tx_start) begin
        start_count++;
      end
      // either status falling means an address was just taken
      if ((fixed_q && !network_state_fixedip) || (dhcp_q && !network_state_dhcp)) begin
        check_ip("local_ip when ready", exp_ip, local_ip);
      end
    end
    fixed_q = network_state_fixedip;
    dhcp_q  = network_state_dhcp;
  end

  initial begin : run_tests
    net_pkg::ip_addr_t     addr;
    net_pkg::ip_addr_t     offer;
    net_pkg::tx_protocol_t exp_p;
    logic [3:0]            req;
    logic [3:0]            exp_en;
    int                    t0;
    int                    t1;
    int                    renew;
    int                    k;

    void'($urandom(93115));
    local_mac = {16'($urandom), 32'($urandom)};

    // static address on a 1G link
    start_test("static_ip");
    addr        = {8'd10, 24'($urandom)};  // never 0 or all ones
    static_ip   = addr;
    link_speed  = 2'b10;
    link_duplex = 1'b1;
    exp_ip      = expected_ip(addr, 1'b0, 32'h0, local_mac);
    apply_reset();
    wait_for(W_FIXEDIP, 3 * TPS, "static address ready", t1);
    check_bit("speed_1gb", 1'b1, speed_1gb);
    check_bit("network_state_dhcp", 1'b1, network_state_dhcp);
    check_count("discover pulses", 0, 0, start_count);
    finish_test();

    // dhcp answers the first discover, 100M link
    start_test("dhcp_success");
    offer      = $urandom | 32'h1;
    static_ip  = 32'h0;
    link_speed = 2'b01;
    exp_ip     = expected_ip(32'h0, 1'b1, offer, local_mac);
    apply_reset();
    wait_for(W_START, 3 * TPS, "discover", t1);
    pulse_success(offer, 32'd0);
    wait_for(W_DHCP, 4, "dhcp address ready", t1);
    check_bit("dhcp_rx_enable", 1'b0, dhcp_rx_enable);
    check_bit("speed_1gb", 1'b0, speed_1gb);
    check_bit("network_state_fixedip", 1'b1, network_state_fixedip);
    finish_test();

    // silent server, all ones is no static address either
    start_test("apipa_fallback");
    static_ip  = 32'hffff_ffff;
    link_speed = 2'b10;
    exp_ip     = expected_ip(32'hffff_ffff, 1'b0, 32'h0, local_mac);
    apply_reset();
    for (k = 0; k < 4; k++) begin
      wait_for(W_START, 10 * TPS, "discover", t1);
      // discovers at 0, 1, 3 and 7 s
      check_count("dhcp_seconds at discover", (1 << k) - 1, (1 << k) - 1,
                  int'(dhcp_seconds));
    end
    wait_for(W_FIXEDIP, 10 * TPS, "link-local address ready", t1);
    check_count("discover pulses", 4, 4, start_count);
    check_count("dhcp_seconds at fallback", net_pkg::DHCP_GIVE_UP_SECONDS,
                net_pkg::DHCP_GIVE_UP_SECONDS, int'(dhcp_seconds));
    check_bit("network_state_dhcp", 1'b1, network_state_dhcp);
    finish_test();

    // lease 6, one acked renewal then one missed ack
    start_test("renewal");
    offer     = $urandom | 32'h1;
    static_ip = 32'h0;
    exp_ip    = expected_ip(32'h0, 1'b1, offer, local_mac);
    renew     = expected_renew_secs(32'd6);
    apply_reset();
    wait_for(W_START, 3 * TPS, "discover", t0);
    pulse_success(offer, 32'd6);
    t0 = cycles;
    wait_for(W_START, (renew + 3) * TPS, "first renewal request", t1);
    check_count("cycles to renewal", (renew - 1) * TPS, (renew + 2) * TPS, t1 - t0);
    pulse_success(offer, 32'd6);
    wait_for(W_START, (renew + 3) * TPS, "second renewal request", t0);
    check_ip("local_ip after ack", exp_ip, local_ip);
    check_bit("network_state_dhcp", 1'b0, network_state_dhcp);
    // no ack now, window then backoff
    wait_for(W_START, (net_pkg::RENEW_ACK_SECONDS + net_pkg::RENEW_BACKOFF_SECONDS + 5) * TPS,
             "request after backoff", t1);
    check_count("cycles after missed ack", net_pkg::RENEW_BACKOFF_SECONDS * TPS,
                (net_pkg::RENEW_ACK_SECONDS + net_pkg::RENEW_BACKOFF_SECONDS + 2) * TPS,
                t1 - t0);
    check_ip("local_ip after backoff", exp_ip, local_ip);
    finish_test();

    // duplex drop with the dhcp address still held, then on a static address
    start_test("link_loss");
    check_bit("network_state_dhcp before loss", 1'b0, network_state_dhcp);
    link_duplex = 1'b0;
    @(negedge tx_clock);
    check_bit("network_state_dhcp after loss", 1'b1, network_state_dhcp);
    addr        = {8'd10, 24'($urandom)};
    static_ip   = addr;
    link_duplex = 1'b1;
    exp_ip      = expected_ip(addr, 1'b0, 32'h0, local_mac);
    apply_reset();
    wait_for(W_FIXEDIP, 3 * TPS, "static address ready", t1);
    link_duplex = 1'b0;
    @(negedge tx_clock);
    check_bit("network_state_fixedip after loss", 1'b1, network_state_fixedip);
    link_duplex = 1'b1;
    wait_for(W_FIXEDIP, 3 * TPS, "address after relink", t1);
    check_ip("local_ip after relink", exp_ip, local_ip);
    finish_test();

    // ----------------------------------------
    // arbitration
    // ----------------------------------------
    start_test("arbitration");
    repeat (16) begin
      req = 4'($urandom_range(1, 15));
      {arp_tx_request, icmp_tx_request, dhcp_tx_request, udp_tx_request} = req;
      exp_p  = expected_grant(req[3], req[2], req[1], req[0]);
      exp_en = 4'b1000 >> exp_p;
      @(negedge tx_clock);
      check_count("enables one cycle after request", 0, 0, int'(enables));
      {arp_tx_request, icmp_tx_request, dhcp_tx_request, udp_tx_request} = 4'b0000;
      @(negedge tx_clock);  // two cycles after the request
      check_protocol("tx_protocol", exp_p, tx_protocol);
      check_count("enables {arp,icmp,dhcp,udp}", int'(exp_en), int'(exp_en), int'(enables));
      repeat ($urandom_range(0, 3)) begin
        @(negedge tx_clock);
        check_count("enables held", int'(exp_en), int'(exp_en), int'(enables));
      end
      tx_active = 1'b1;
      @(negedge tx_clock);
      tx_active = 1'b0;
      check_count("enables after tx_active", 0, 0, int'(enables));
      @(negedge tx_clock);
    end
    finish_test();

    $display("%0d tests, %0d failed, %0d mismatches", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- src/net_control.sv
/*
  Ethernet endpoint control core, top level.
  One-second prescaler, bring-up sequencer and
  transmit arbiter on the tx_clock domain.
*/
module net_control #(
  parameter int ticks_per_second = 2500000,
  parameter int retry_gap_cycles = 131072
) (
  input  logic                  tx_clock,
  input  logic                  rst_n,
  // link and configuration
  input  net_pkg::link_speed_t  link_speed,
  input  logic                  link_duplex,
  input  net_pkg::ip_addr_t     static_ip,
  input  net_pkg::mac_addr_t    local_mac,
  // dhcp results
  input  logic                  dhcp_success,
  input  net_pkg::ip_addr_t     ip_accept,
  input  net_pkg::lease_t       lease,
  // transmit requests
  input  logic                  arp_tx_request,
  input  logic                  icmp_tx_request,
  input  logic                  dhcp_tx_request,
  input  logic                  udp_tx_request,
  input  logic                  tx_active,
  // status
  output net_pkg::ip_addr_t     local_ip,
  output logic                  network_state_dhcp,
  output logic                  network_state_fixedip,
  output logic                  speed_1gb,
  // dhcp control
  output logic                  dhcp_tx_start,
  output logic                  dhcp_rx_enable,
  output net_pkg::dhcp_secs_t   dhcp_seconds,
  // transmit grant
  output net_pkg::tx_protocol_t tx_protocol,
  output logic                  arp_tx_enable,
  output logic                  icmp_tx_enable,
  output logic                  dhcp_tx_enable,
  output logic                  udp_tx_enable
);

  logic tick;          // one cycle per second
  logic tick_restart;  // sequencer starts a fresh second

  // ----------------------------------------
  // timebase and sequencer
  // ----------------------------------------
  second_tick #(
    .ticks_per_second(ticks_per_second)
  ) i_second_tick (
    .tx_clock    (tx_clock),
    .rst_n       (rst_n),
    .tick_restart(tick_restart),
    .tick        (tick)
  );

  link_sequencer #(
    .retry_gap_cycles(retry_gap_cycles)
  ) i_link_sequencer (
    .tx_clock             (tx_clock),
    .rst_n                (rst_n),
    .tick                 (tick),
    .link_speed           (link_speed),
    .link_duplex          (link_duplex),
    .static_ip            (static_ip),
    .local_mac            (local_mac),
    .dhcp_success         (dhcp_success),
    .ip_accept            (ip_accept),
    .lease                (lease),
    .tick_restart         (tick_restart),
    .local_ip             (local_ip),
    .network_state_dhcp   (network_state_dhcp),
    .network_state_fixedip(network_state_fixedip),
    .speed_1gb            (speed_1gb),
    .dhcp_tx_start        (dhcp_tx_start),
    .dhcp_rx_enable       (dhcp_rx_enable),
    .dhcp_seconds         (dhcp_seconds)
  );

  // ----------------------------------------
  // shared transmitter
  // ----------------------------------------
  tx_arbiter i_tx_arbiter (
    .tx_clock       (tx_clock),
    .rst_n          (rst_n),
    .arp_tx_request (arp_tx_request),
    .icmp_tx_request(icmp_tx_request),
    .dhcp_tx_request(dhcp_tx_request),
    .udp_tx_request (udp_tx_request),
    .tx_active      (tx_active),
    .tx_protocol    (tx_protocol),
    .arp_tx_enable  (arp_tx_enable),
    .icmp_tx_enable (icmp_tx_enable),
    .dhcp_tx_enable (dhcp_tx_enable),
    .udp_tx_enable  (udp_tx_enable)
  );

endmodule

//--- src/tx_arbiter.sv
/*
  Transmitter arbiter.
  Fixed priority arp > icmp > dhcp > udp, registered winner,
  ready then start staging, grant held until tx_active.
*/
module tx_arbiter (
  input  logic                  tx_clock,
  input  logic                  rst_n,
  input  logic                  arp_tx_request,
  input  logic                  icmp_tx_request,
  input  logic                  dhcp_tx_request,
  input  logic                  udp_tx_request,
  input  logic                  tx_active,
  output net_pkg::tx_protocol_t tx_protocol,
  output logic                  arp_tx_enable,
  output logic                  icmp_tx_enable,
  output logic                  dhcp_tx_enable,
  output logic                  udp_tx_enable
);

  logic tx_ready;  // winner latched
  logic tx_start;  // enable of the winner is up

  always_ff @(posedge tx_clock or negedge rst_n) begin
    if (!rst_n) begin
      tx_ready    <= 1'b0;
      tx_start    <= 1'b0;
      tx_protocol <= net_pkg::PT_ARP;
    end else if (tx_active) begin
      // sender picked it up, release the grant
      tx_ready <= 1'b0;
      tx_start <= 1'b0;
    end else if (tx_ready) begin
      tx_start <= 1'b1;  // requests wait while a grant is pending
    end else if (arp_tx_request) begin
      tx_protocol <= net_pkg::PT_ARP;
      tx_ready    <= 1'b1;
    end else if (icmp_tx_request) begin
      tx_protocol <= net_pkg::PT_ICMP;
      tx_ready    <= 1'b1;
    end else if (dhcp_tx_request) begin
      tx_protocol <= net_pkg::PT_DHCP;
      tx_ready    <= 1'b1;
    end else if (udp_tx_request) begin
      tx_protocol <= net_pkg::PT_UDP;
      tx_ready    <= 1'b1;
    end
  end

  // decode of the registered winner
  assign arp_tx_enable  = tx_start && (tx_protocol == net_pkg::PT_ARP);
  assign icmp_tx_enable = tx_start && (tx_protocol == net_pkg::PT_ICMP);
  assign dhcp_tx_enable = tx_start && (tx_protocol == net_pkg::PT_DHCP);
  assign udp_tx_enable  = tx_start && (tx_protocol == net_pkg::PT_UDP);

  a_one_enable : assert property (
    @(posedge tx_clock) disable iff (!rst_n)
    $onehot0({arp_tx_enable, icmp_tx_enable, dhcp_tx_enable, udp_tx_enable})
  ) else $error("more than one transmit enable");

  // winner frozen for the whole grant
  a_protocol_held : assert property (
    @(posedge tx_clock) disable iff (!rst_n) tx_start |=> (!tx_start || $stable(tx_protocol))
  ) else $error("tx_protocol changed during a grant");

endmodule

//--- src/link_sequencer.sv
/*
  Network bring-up sequencer.
  Link detect and settle, static address or dhcp with
  retransmits at 1/3/7 s, link-local fallback after 15 s,
  lease renewal at half lease with ack window and backoff.
*/
module link_sequencer #(
  parameter int retry_gap_cycles = 131072
) (
  input  logic                 tx_clock,
  input  logic                 rst_n,
  input  logic                 tick,
  input  net_pkg::link_speed_t link_speed,
  input  logic                 link_duplex,
  input  net_pkg::ip_addr_t    static_ip,
  input  net_pkg::mac_addr_t   local_mac,
  input  logic                 dhcp_success,
  input  net_pkg::ip_addr_t    ip_accept,
  input  net_pkg::lease_t      lease,
  output logic                 tick_restart,
  output net_pkg::ip_addr_t    local_ip,
  output logic                 network_state_dhcp,
  output logic                 network_state_fixedip,
  output logic                 speed_1gb,
  output logic                 dhcp_tx_start,
  output logic                 dhcp_rx_enable,
  output net_pkg::dhcp_secs_t  dhcp_seconds
);

  localparam int GW = $clog2(retry_gap_cycles + 1);
  localparam logic [GW-1:0] GAP_LOAD = GW'(retry_gap_cycles);

  net_pkg::net_state_t  state;
  net_pkg::renew_secs_t renew_secs;    // renewal / ack / backoff seconds
  logic [GW-1:0]        gap_count;     // pause before a retransmit

  logic                 link_up;
  logic                 static_valid;
  logic                 past_connect;
  net_pkg::ip_addr_t    apipa_ip;
  net_pkg::renew_secs_t renew_reload;

  // ----------------------------------------
  // link and address decode
  // ----------------------------------------
  assign link_up      = link_duplex && (link_speed[1] != link_speed[0]);  // 01 or 10
  assign static_valid = (static_ip != '0) && (static_ip != '1);
  assign apipa_ip     = {net_pkg::APIPA_PREFIX, local_mac[15:0]};
  assign past_connect = (state != net_pkg::ST_START) && (state != net_pkg::ST_PHY_CONNECT);

  // half the lease, or the default when the server gave none
  assign renew_reload = (lease == '0) ?
                        net_pkg::renew_secs_t'(net_pkg::DEFAULT_RENEW_SECONDS) :
                        net_pkg::renew_secs_t'(lease >> 1);

  // new second starts at connect, at each request and on each ack
  assign tick_restart = (state == net_pkg::ST_PHY_CONNECT && link_up) ||
                        (state == net_pkg::ST_DHCP_REQUEST) ||
                        (state == net_pkg::ST_RENEW_REQ) ||
                        ((state == net_pkg::ST_DHCP || state == net_pkg::ST_RENEW_ACK) &&
                         dhcp_success);

  // ----------------------------------------
  // state machine
  // ----------------------------------------
  always_ff @(posedge tx_clock or negedge rst_n) begin
    if (!rst_n) begin
      state                 <= net_pkg::ST_START;
      local_ip              <= '0;
      network_state_dhcp    <= 1'b1;  // high = no address yet
      network_state_fixedip <= 1'b1;
      speed_1gb             <= 1'b0;
      dhcp_tx_start         <= 1'b0;
      dhcp_rx_enable        <= 1'b0;
      dhcp_seconds          <= '0;
      renew_secs            <= '0;
      gap_count             <= '0;
    end else begin
      dhcp_tx_start <= 1'b0;  // single-cycle pulse

      if (past_connect && !link_up) begin
        // link gone, drop the address state and wait again
        network_state_dhcp    <= 1'b1;
        network_state_fixedip <= 1'b1;
        dhcp_rx_enable        <= 1'b0;
        state                 <= net_pkg::ST_PHY_CONNECT;
      end else begin
        case (state)
          net_pkg::ST_START: begin
            speed_1gb <= 1'b0;
            state     <= net_pkg::ST_PHY_CONNECT;
          end

          net_pkg::ST_PHY_CONNECT: begin
            if (link_up) begin
              speed_1gb <= link_speed[1];  // latched once per connect
              state     <= net_pkg::ST_PHY_SETTLE;
            end
          end

          net_pkg::ST_PHY_SETTLE: begin
            if (tick) begin  // one quiet second done
              if (static_valid) begin
                local_ip <= static_ip;
                state    <= net_pkg::ST_RUNNING;
              end else begin
                local_ip     <= '0;  // dhcp needs 0.0.0.0
                dhcp_seconds <= '0;
                state        <= net_pkg::ST_DHCP_REQUEST;
              end
            end
          end

          net_pkg::ST_DHCP_REQUEST: begin
            dhcp_tx_start  <= 1'b1;  // discover
            dhcp_rx_enable <= 1'b1;
            state          <= net_pkg::ST_DHCP;
          end

          net_pkg::ST_DHCP: begin
            if (dhcp_success) begin
              local_ip           <= ip_accept;
              network_state_dhcp <= 1'b0;
              dhcp_rx_enable     <= 1'b0;
              dhcp_seconds       <= '0;
              renew_secs         <= renew_reload;
              state              <= net_pkg::ST_RENEW_WAIT;
            end else if (tick) begin
              dhcp_seconds <= dhcp_seconds + 1'b1;  // old value decides below
              // retransmit after seconds 1, 3 and 7
              if (dhcp_seconds == 4'd0 || dhcp_seconds == 4'd2 || dhcp_seconds == 4'd6) begin
                gap_count <= GAP_LOAD;
                state     <= net_pkg::ST_DHCP_RETRY;
              end else if (dhcp_seconds ==
                           net_pkg::dhcp_secs_t'(net_pkg::DHCP_GIVE_UP_SECONDS - 1)) begin
                local_ip <= apipa_ip;  // no server, go link-local
                state    <= net_pkg::ST_RUNNING;
              end
            end
          end

          net_pkg::ST_DHCP_RETRY: begin
            dhcp_rx_enable <= 1'b0;
            if (gap_count == '0) begin
              state <= net_pkg::ST_DHCP_REQUEST;
            end else begin
              gap_count <= gap_count - 1'b1;
            end
          end

          net_pkg::ST_RUNNING: begin  // static or link-local address
            dhcp_rx_enable        <= 1'b0;
            network_state_fixedip <= 1'b0;
          end

          net_pkg::ST_RENEW_WAIT: begin
            dhcp_rx_enable <= 1'b0;
            if (renew_secs == '0) begin
              state <= net_pkg::ST_RENEW_REQ;
            end else if (tick) begin
              renew_secs <= renew_secs - 1'b1;
            end
          end

          net_pkg::ST_RENEW_REQ: begin
            dhcp_tx_start  <= 1'b1;  // renewal request, address stays in use
            dhcp_rx_enable <= 1'b1;
            renew_secs     <= net_pkg::renew_secs_t'(net_pkg::RENEW_ACK_SECONDS);
            state          <= net_pkg::ST_RENEW_ACK;
          end

          net_pkg::ST_RENEW_ACK: begin
            if (dhcp_success) begin
              dhcp_rx_enable <= 1'b0;
              renew_secs     <= renew_reload;
              state          <= net_pkg::ST_RENEW_WAIT;
            end else if (renew_secs == '0) begin
              dhcp_rx_enable <= 1'b0;  // ack window closed
              renew_secs     <= net_pkg::renew_secs_t'(net_pkg::RENEW_BACKOFF_SECONDS);
              state          <= net_pkg::ST_RENEW_WAIT;
            end else if (tick) begin
              renew_secs <= renew_secs - 1'b1;
            end
          end

          default: state <= net_pkg::ST_START;
        endcase
      end
    end
  end

  // ----------------------------------------
  // checks
  // ----------------------------------------
  a_tx_start_pulse : assert property (
    @(posedge tx_clock) disable iff (!rst_n) dhcp_tx_start |=> !dhcp_tx_start
  ) else $error("dhcp_tx_start longer than one cycle");

  // dhcp state only reports ready with a real address loaded
  a_dhcp_has_ip : assert property (
    @(posedge tx_clock) disable iff (!rst_n) !network_state_dhcp |-> (local_ip != '0)
  ) else $error("dhcp address ready but local_ip is zero");

endmodule

//--- src/second_tick.sv
/*
  One-second prescaler.
  Down-counter on tx_clock, one-cycle tick at zero,
  restartable so a new second starts on demand.
*/
module second_tick #(
  parameter int ticks_per_second = 2500000
) (
  input  logic tx_clock,
  input  logic rst_n,
  input  logic tick_restart,
  output logic tick
);

  localparam int CW = $clog2(ticks_per_second + 1);
  localparam logic [CW-1:0] RELOAD = CW'(ticks_per_second - 1);

  logic [CW-1:0] count;  // cycles left in this second

  assign tick = (count == '0);

  always_ff @(posedge tx_clock or negedge rst_n) begin
    if (!rst_n) begin
      count <= RELOAD;
    end else if (tick_restart || tick) begin
      count <= RELOAD;  // first tick lands a full second later
    end else begin
      count <= count - 1'b1;
    end
  end

  // reload at zero keeps the tick to a single cycle
  a_tick_single : assert property (
    @(posedge tx_clock) disable iff (!rst_n) tick |=> !tick
  ) else $error("second tick high for two cycles");

endmodule

//--- src/net_pkg.sv
/*
  Shared definitions for the ethernet control core.
  Address, lease and timer types, sequencer states,
  transmitter users and the dhcp / fallback constants.
*/
package net_pkg;

  // ----------------------------------------
  // addresses and timers
  // ----------------------------------------
  typedef logic [31:0] ip_addr_t;
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] lease_t;       // seconds, as granted by the server
  typedef logic [17:0] renew_secs_t;  // seconds left before renewal
  typedef logic [3:0]  dhcp_secs_t;   // seconds since discover began, goes into the packet
  typedef logic [1:0]  link_speed_t;  // 01 = 100M, 10 = 1000M, 00/11 no link

  // bring-up sequencer states
  typedef enum logic [3:0] {
    ST_START        = 4'd0,
    ST_PHY_CONNECT  = 4'd1,
    ST_PHY_SETTLE   = 4'd2,
    ST_DHCP_REQUEST = 4'd3,
    ST_DHCP         = 4'd4,
    ST_DHCP_RETRY   = 4'd5,
    ST_RUNNING      = 4'd6,
    ST_RENEW_WAIT   = 4'd7,
    ST_RENEW_REQ    = 4'd8,
    ST_RENEW_ACK    = 4'd9
  } net_state_t;

  // users of the shared transmitter, arp wins
  typedef enum logic [1:0] {
    PT_ARP  = 2'd0,
    PT_ICMP = 2'd1,
    PT_DHCP = 2'd2,
    PT_UDP  = 2'd3
  } tx_protocol_t;

  // ----------------------------------------
  // protocol constants
  // ----------------------------------------
  localparam logic [15:0] APIPA_PREFIX = {8'd169, 8'd254};  // link-local 169.254
  localparam int DHCP_GIVE_UP_SECONDS  = 15;
  localparam int DEFAULT_RENEW_SECONDS = 43200;  // 12 h when no lease given
  localparam int RENEW_ACK_SECONDS     = 20;
  localparam int RENEW_BACKOFF_SECONDS = 300;    // pause after a lost ack

endpackage
